// ==== source/manycore_pkg.sv ====
// shared widths, packet layouts and opcodes for the manycore network tile
// import with a wildcard in the module header of any block that needs them
// packet fields are packed low to high and addressed through the _ofs_lp offsets

package manycore_pkg;

  // ------------------------------
  // base widths
  // ------------------------------
  localparam int x_cord_width_lp = 4;
  localparam int y_cord_width_lp = 4;
  localparam int addr_width_lp   = 8;
  localparam int data_width_lp   = 32;
  localparam int op_width_lp     = 2;

  // request fifo depth in the endpoint
  localparam int req_fifo_els_lp = 4;
  // local word memory size, one word per address
  localparam int mem_words_lp    = 256;

  // ------------------------------
  // field vectors
  // ------------------------------
  typedef logic [x_cord_width_lp-1:0] x_cord_t;
  typedef logic [y_cord_width_lp-1:0] y_cord_t;
  typedef logic [addr_width_lp-1:0]   addr_t;
  typedef logic [data_width_lp-1:0]   data_t;
  typedef logic [op_width_lp-1:0]     op_t;

  // request opcodes
  localparam op_t op_load_lp  = 2'd0;
  localparam op_t op_store_lp = 2'd1;

  // ------------------------------
  // request packet layout
  // ------------------------------
  // op | addr | data | src_x | src_y | dst_x | dst_y, low bits first
  localparam int op_ofs_lp    = 0;
  localparam int addr_ofs_lp  = op_ofs_lp + op_width_lp;
  localparam int data_ofs_lp  = addr_ofs_lp + addr_width_lp;
  localparam int src_x_ofs_lp = data_ofs_lp + data_width_lp;
  localparam int src_y_ofs_lp = src_x_ofs_lp + x_cord_width_lp;
  localparam int dst_x_ofs_lp = src_y_ofs_lp + y_cord_width_lp;
  localparam int dst_y_ofs_lp = dst_x_ofs_lp + x_cord_width_lp;

  // 58 bits total
  localparam int packet_width_lp = dst_y_ofs_lp + y_cord_width_lp;

  typedef logic [packet_width_lp-1:0] packet_t;

  // ------------------------------
  // return packet layout
  // ------------------------------
  // type | data | dst_x | dst_y, low bits first
  localparam int ret_type_ofs_lp  = 0;
  localparam int ret_data_ofs_lp  = ret_type_ofs_lp + 1;
  localparam int ret_dst_x_ofs_lp = ret_data_ofs_lp + data_width_lp;
  localparam int ret_dst_y_ofs_lp = ret_dst_x_ofs_lp + x_cord_width_lp;

  // 41 bits total
  localparam int return_packet_width_lp = ret_dst_y_ofs_lp + y_cord_width_lp;

  typedef logic [return_packet_width_lp-1:0] return_packet_t;

  // return type bit
  // load data carries the word, store ack carries zero
  localparam logic ret_type_load_lp  = 1'b0;
  localparam logic ret_type_store_lp = 1'b1;

endpackage

// ==== source/fifo_small.sv ====
// small circular-buffer FIFO, valid/ready on the write side, valid/yumi on the read side
// a word written at one edge is visible on data_o right after that edge
// els_p must be at least 2; any depth works, not only powers of two

`timescale 1ns/1ps

module fifo_small #(
  parameter int width_p = 8,
  parameter int els_p   = 4
) (
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               v_i,
  input  logic [width_p-1:0] data_i,
  output logic               ready_o,

  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  localparam int ptr_width_lp = $clog2(els_p);

  logic [width_p-1:0]      mem_r [els_p];
  logic [ptr_width_lp-1:0] wptr_r, rptr_r;
  logic [ptr_width_lp-1:0] wptr_next, rptr_next;
  logic                    full_r, empty_r;
  logic                    enq, deq;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign enq     = v_i & ~full_r;
  assign deq     = yumi_i;

  // wrap explicitly so odd depths work
  assign wptr_next = (wptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;
  assign rptr_next = (rptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;

  // head entry straight out of the storage registers
  assign data_o = mem_r[rptr_r];

  // pointers and occupancy flags
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end else begin
      if (enq)
        wptr_r <= wptr_next;
      if (deq)
        rptr_r <= rptr_next;
      // flags only move when the count changes
      if (enq & ~deq) begin
        empty_r <= 1'b0;
        full_r  <= (wptr_next == rptr_r);
      end else if (deq & ~enq) begin
        full_r  <= 1'b0;
        empty_r <= (rptr_next == wptr_r);
      end
    end
  end

  // storage array
  always_ff @(posedge clk_i) begin
    if (enq)
      mem_r[wptr_r] <= data_i;
  end

  // consumer may only take what is there
  a_no_yumi_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

  // a refused write must be offered again unchanged
  a_hold_while_not_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    v_i && !ready_o |=> v_i && $stable(data_i));

endmodule

// ==== source/two_fifo.sv ====
// two-entry FIFO for the return path
// a full FIFO still takes a new entry in a cycle where the head is dequeued

`timescale 1ns/1ps

module two_fifo #(
  parameter int width_p = 8
) (
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               v_i,
  input  logic [width_p-1:0] data_i,
  output logic               ready_o,

  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  logic [width_p-1:0] mem_r [2];
  // head selects the read entry, tail the write entry
  logic               head_r, tail_r;
  logic               full_r, empty_r;
  logic               enq, deq;

  // ready reports space only, the same-cycle dequeue case is handled in enq
  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[head_r];

  assign deq = yumi_i;
  assign enq = v_i & (~full_r | yumi_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_r  <= 1'b0;
      tail_r  <= 1'b0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end else begin
      if (enq)
        tail_r <= ~tail_r;
      if (deq)
        head_r <= ~head_r;
      // one in, none out: second entry fills the fifo
      if (enq & ~deq) begin
        empty_r <= 1'b0;
        full_r  <= ~empty_r;
      end else if (deq & ~enq) begin
        full_r  <= 1'b0;
        empty_r <= ~full_r;
      end
    end
  end

  // when full, tail == head and the old head leaves in the same cycle
  always_ff @(posedge clk_i) begin
    if (enq)
      mem_r[tail_r] <= data_i;
  end

  // upstream never waits, so a full fifo must drain when something arrives
  a_deq_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    full_r && v_i |-> yumi_i);

endmodule

// ==== source/manycore_endpoint.sv ====
// mesh link endpoint of a tile
// queues incoming requests and incoming returns, passes outgoing traffic to the link
// the reverse link is always accepted, so the return FIFO must be drained when full

`timescale 1ns/1ps

module manycore_endpoint
  import manycore_pkg::*;
(
  input  logic           clk_i,
  input  logic           reset_i,

  // mesh link
  input  logic           link_fwd_v_i,
  input  packet_t        link_fwd_data_i,
  output logic           link_fwd_ready_o,
  output logic           link_fwd_v_o,
  output packet_t        link_fwd_data_o,
  input  logic           link_fwd_ready_i,
  input  logic           link_rev_v_i,
  input  return_packet_t link_rev_data_i,
  output logic           link_rev_v_o,
  output return_packet_t link_rev_data_o,
  input  logic           link_rev_ready_i,

  // incoming request
  output logic           packet_v_o,
  output packet_t        packet_o,
  input  logic           packet_yumi_i,

  // outgoing response
  input  logic           return_packet_v_i,
  input  return_packet_t return_packet_i,
  output logic           return_packet_ready_o,

  // outgoing request
  input  logic           packet_v_i,
  input  packet_t        packet_i,
  output logic           packet_ready_o,

  // incoming response
  output logic           return_packet_v_o,
  output return_packet_t return_packet_o,
  input  logic           return_packet_yumi_i,
  output logic           return_packet_fifo_full_o
);

  // ------------------------------
  // incoming requests
  // ------------------------------
  // local memory may stall, so requests wait here
  fifo_small #(
    .width_p(packet_width_lp),
    .els_p  (req_fifo_els_lp)
  ) req_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (link_fwd_v_i),
    .data_i (link_fwd_data_i),
    .ready_o(link_fwd_ready_o),
    .v_o    (packet_v_o),
    .data_o (packet_o),
    .yumi_i (packet_yumi_i)
  );

  // ------------------------------
  // outgoing responses
  // ------------------------------
  // straight onto the reverse link
  assign link_rev_v_o          = return_packet_v_i;
  assign link_rev_data_o       = return_packet_i;
  assign return_packet_ready_o = link_rev_ready_i;

  // ------------------------------
  // outgoing requests
  // ------------------------------
  assign link_fwd_v_o    = packet_v_i;
  assign link_fwd_data_o = packet_i;
  assign packet_ready_o  = link_fwd_ready_i;

  // ------------------------------
  // incoming returns
  // ------------------------------
  logic returned_fifo_ready;

  two_fifo #(
    .width_p(return_packet_width_lp)
  ) returned_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (link_rev_v_i),
    .data_i (link_rev_data_i),
    .ready_o(returned_fifo_ready),
    .v_o    (return_packet_v_o),
    .data_o (return_packet_o),
    .yumi_i (return_packet_yumi_i)
  );

  // no space left means both entries held
  assign return_packet_fifo_full_o = ~returned_fifo_ready;

endmodule

// ==== source/local_mem_responder.sv ====
// serves load and store requests against the tile's local word memory
// one request in, one return packet out, held in a single output slot
// the return goes back to the request's source coordinates

`timescale 1ns/1ps

module local_mem_responder
  import manycore_pkg::*;
(
  input  logic           clk_i,
  input  logic           reset_i,

  // request in, valid/yumi
  input  logic           packet_v_i,
  input  packet_t        packet_i,
  output logic           packet_yumi_o,

  // return out, valid/ready
  output logic           return_packet_v_o,
  output return_packet_t return_packet_o,
  input  logic           return_packet_ready_i
);

  typedef enum logic {
    resp_idle_s,
    resp_hold_s
  } resp_state_e;

  resp_state_e    state_r;
  data_t          mem_r [mem_words_lp];
  return_packet_t ret_r;
  return_packet_t ret_next;

  // request fields
  op_t     req_op;
  addr_t   req_addr;
  data_t   req_data;
  x_cord_t req_src_x;
  y_cord_t req_src_y;
  logic    req_take;
  logic    req_is_store;

  assign req_op    = packet_i[op_ofs_lp +: op_width_lp];
  assign req_addr  = packet_i[addr_ofs_lp +: addr_width_lp];
  assign req_data  = packet_i[data_ofs_lp +: data_width_lp];
  assign req_src_x = packet_i[src_x_ofs_lp +: x_cord_width_lp];
  assign req_src_y = packet_i[src_y_ofs_lp +: y_cord_width_lp];

  // ------------------------------
  // output slot control
  // ------------------------------
  // slot free, or being drained this cycle
  assign req_take = packet_v_i &
                    ((state_r == resp_idle_s) | return_packet_ready_i);

  assign packet_yumi_o     = req_take;
  assign return_packet_v_o = (state_r == resp_hold_s);
  assign return_packet_o   = ret_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= resp_idle_s;
    end else if (req_take) begin
      state_r <= resp_hold_s;
    end else if (return_packet_ready_i) begin
      state_r <= resp_idle_s;
    end
  end

  // ------------------------------
  // decode and return build
  // ------------------------------
  always_comb begin
    ret_next = '0;
    ret_next[ret_dst_x_ofs_lp +: x_cord_width_lp] = req_src_x;
    ret_next[ret_dst_y_ofs_lp +: y_cord_width_lp] = req_src_y;
    case (req_op)
      op_store_lp: begin
        // ack only, data field stays zero
        req_is_store = 1'b1;
        ret_next[ret_type_ofs_lp] = ret_type_store_lp;
      end
      default: begin
        // loads and the unused opcodes
        req_is_store = 1'b0;
        ret_next[ret_type_ofs_lp] = ret_type_load_lp;
        ret_next[ret_data_ofs_lp +: data_width_lp] = mem_r[req_addr];
      end
    endcase
  end

  // memory write and return capture on the same edge
  always_ff @(posedge clk_i) begin
    if (req_take) begin
      ret_r <= ret_next;
      if (req_is_store)
        mem_r[req_addr] <= req_data;
    end
  end

  // a waiting request must not change before it is taken
  a_req_hold_until_taken: assert property (@(posedge clk_i) disable iff (reset_i)
    packet_v_i && !packet_yumi_o |=>
      packet_v_i && $stable(packet_i));

endmodule

// ==== source/manycore_tile.sv ====
// one network tile: link endpoint plus a local memory that answers requests
// outgoing requests and incoming returns belong to the local client on plain ports

`timescale 1ns/1ps

module manycore_tile
  import manycore_pkg::*;
(
  input  logic           clk_i,
  input  logic           reset_i,

  // mesh link
  input  logic           link_fwd_v_i,
  input  packet_t        link_fwd_data_i,
  output logic           link_fwd_ready_o,
  output logic           link_fwd_v_o,
  output packet_t        link_fwd_data_o,
  input  logic           link_fwd_ready_i,
  input  logic           link_rev_v_i,
  input  return_packet_t link_rev_data_i,
  output logic           link_rev_v_o,
  output return_packet_t link_rev_data_o,
  input  logic           link_rev_ready_i,

  // client outgoing request
  input  logic           packet_v_i,
  input  packet_t        packet_i,
  output logic           packet_ready_o,

  // client incoming response
  output logic           return_packet_v_o,
  output return_packet_t return_packet_o,
  input  logic           return_packet_yumi_i,
  output logic           return_packet_fifo_full_o
);

  // endpoint to memory, requests
  logic           req_v;
  packet_t        req_packet;
  logic           req_yumi;

  // memory to endpoint, returns
  logic           resp_v;
  return_packet_t resp_packet;
  logic           resp_ready;

  manycore_endpoint u_endpoint (
    .clk_i                    (clk_i),
    .reset_i                  (reset_i),
    .link_fwd_v_i             (link_fwd_v_i),
    .link_fwd_data_i          (link_fwd_data_i),
    .link_fwd_ready_o         (link_fwd_ready_o),
    .link_fwd_v_o             (link_fwd_v_o),
    .link_fwd_data_o          (link_fwd_data_o),
    .link_fwd_ready_i         (link_fwd_ready_i),
    .link_rev_v_i             (link_rev_v_i),
    .link_rev_data_i          (link_rev_data_i),
    .link_rev_v_o             (link_rev_v_o),
    .link_rev_data_o          (link_rev_data_o),
    .link_rev_ready_i         (link_rev_ready_i),
    .packet_v_o               (req_v),
    .packet_o                 (req_packet),
    .packet_yumi_i            (req_yumi),
    .return_packet_v_i        (resp_v),
    .return_packet_i          (resp_packet),
    .return_packet_ready_o    (resp_ready),
    .packet_v_i               (packet_v_i),
    .packet_i                 (packet_i),
    .packet_ready_o           (packet_ready_o),
    .return_packet_v_o        (return_packet_v_o),
    .return_packet_o          (return_packet_o),
    .return_packet_yumi_i     (return_packet_yumi_i),
    .return_packet_fifo_full_o(return_packet_fifo_full_o)
  );

  local_mem_responder u_mem (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .packet_v_i           (req_v),
    .packet_i             (req_packet),
    .packet_yumi_o        (req_yumi),
    .return_packet_v_o    (resp_v),
    .return_packet_o      (resp_packet),
    .return_packet_ready_i(resp_ready)
  );

endmodule

// ==== tests/tb_manycore_tile.sv ====
// testbench for the manycore tile
// drives the mesh link and the client ports, checks every return against a model memory
// compile with verilog.f, top module tb_manycore_tile

`timescale 1ns/1ps

module tb_manycore_tile
  import manycore_pkg::*;
();

  localparam int clk_half_lp       = 20;
  // requests, returns and passthrough cycles over all phases
  localparam int num_txn_lp        = 2 + 40 + 40 + 5 + 2 + 30 + 20;
  localparam int timeout_cycles_lp = num_txn_lp * 20 + 200;
  localparam x_cord_t tile_x_lp    = 4'd1;
  localparam y_cord_t tile_y_lp    = 4'd2;

  logic           clk_i;
  logic           reset_i;
  logic           link_fwd_v_i;
  packet_t        link_fwd_data_i;
  logic           link_fwd_ready_o;
  logic           link_fwd_v_o;
  packet_t        link_fwd_data_o;
  logic           link_fwd_ready_i;
  logic           link_rev_v_i;
  return_packet_t link_rev_data_i;
  logic           link_rev_v_o;
  return_packet_t link_rev_data_o;
  logic           link_rev_ready_i;
  logic           packet_v_i;
  packet_t        packet_i;
  logic           packet_ready_o;
  logic           return_packet_v_o;
  return_packet_t return_packet_o;
  logic           return_packet_yumi_i;
  logic           return_packet_fifo_full_o;

  // expected traffic and model state
  return_packet_t exp_rev_q[$];
  return_packet_t exp_ret_q[$];
  data_t          model_mem [mem_words_lp];
  addr_t          written_q[$];

  int    value_errors;
  int    other_errors;
  int    accepted_cnt;
  int    answered_cnt;
  // 0 ready, 1 random stalls, 2 held low
  int    rev_mode;
  logic  checks_on;
  string test_name;

  manycore_tile u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #clk_half_lp clk_i = ~clk_i;
  end

  // ------------------------------
  // reference model
  // ------------------------------
  // return packet the tile owes for a request, memory updated in accept order
  function automatic return_packet_t ref_mem_response(input packet_t pkt);
    return_packet_t ret;
    addr_t          addr;
    ret  = '0;
    addr = pkt[addr_ofs_lp +: addr_width_lp];
    ret[ret_dst_x_ofs_lp +: x_cord_width_lp] = pkt[src_x_ofs_lp +: x_cord_width_lp];
    ret[ret_dst_y_ofs_lp +: y_cord_width_lp] = pkt[src_y_ofs_lp +: y_cord_width_lp];
    if (pkt[op_ofs_lp +: op_width_lp] == op_store_lp) begin
      model_mem[addr]      = pkt[data_ofs_lp +: data_width_lp];
      ret[ret_type_ofs_lp] = 1'b1;
    end else begin
      ret[ret_data_ofs_lp +: data_width_lp] = model_mem[addr];
    end
    return ret;
  endfunction

  function automatic packet_t make_request(input op_t op, input addr_t addr,
                                           input data_t data, input x_cord_t sx,
                                           input y_cord_t sy);
    packet_t pkt;
    pkt = '0;
    pkt[op_ofs_lp +: op_width_lp]        = op;
    pkt[addr_ofs_lp +: addr_width_lp]    = addr;
    pkt[data_ofs_lp +: data_width_lp]    = data;
    pkt[src_x_ofs_lp +: x_cord_width_lp] = sx;
    pkt[src_y_ofs_lp +: y_cord_width_lp] = sy;
    pkt[dst_x_ofs_lp +: x_cord_width_lp] = tile_x_lp;
    pkt[dst_y_ofs_lp +: y_cord_width_lp] = tile_y_lp;
    return pkt;
  endfunction

  // loads only hit words already stored, memory has no reset
  function automatic packet_t random_request();
    op_t   op;
    addr_t addr;
    if (written_q.size() == 0 || ($urandom % 2) == 0) begin
      op   = op_store_lp;
      addr = addr_t'($urandom);
      written_q.push_back(addr);
    end else begin
      op   = op_load_lp;
      addr = written_q[$urandom_range(written_q.size() - 1, 0)];
    end
    return make_request(op, addr, data_t'($urandom), x_cord_t'($urandom),
                        y_cord_t'($urandom));
  endfunction

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      value_errors++;
      $display("ERROR %s: %s expected %b actual %b", test_name, name, expected, actual);
    end
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_request(input packet_t pkt);
    link_fwd_v_i    = 1'b1;
    link_fwd_data_i = pkt;
    // ready only moves on rising edges
    while (!link_fwd_ready_o)
      @(negedge clk_i);
    @(negedge clk_i);
    link_fwd_v_i = 1'b0;
  endtask

  task automatic send_random_requests(input int count);
    repeat (count) begin
      send_request(random_request());
      repeat ($urandom % 3) @(negedge clk_i);
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_rev_q.size() != 0 && cycles < 200) begin
      @(negedge clk_i);
      cycles++;
    end
    if (exp_rev_q.size() != 0) begin
      other_errors++;
      $display("%s: %0d responses never came back", test_name, exp_rev_q.size());
    end
  endtask

  task automatic drain_returns();
    int cycles;
    cycles = 0;
    while (return_packet_v_o && cycles < 10) begin
      return_packet_yumi_i = 1'b1;
      @(negedge clk_i);
      cycles++;
    end
    return_packet_yumi_i = 1'b0;
    if (exp_ret_q.size() != 0) begin
      other_errors++;
      $display("%s: %0d returns were never delivered", test_name, exp_ret_q.size());
    end
  endtask

  // ------------------------------
  // reverse ready driver
  // ------------------------------
  initial begin
    link_rev_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      case (rev_mode)
        1:       link_rev_ready_i = ($urandom % 3) != 0;
        2:       link_rev_ready_i = 1'b0;
        default: link_rev_ready_i = 1'b1;
      endcase
    end
  end

  // ------------------------------
  // compare processes
  // ------------------------------
  // responses leave in request order, each new accept gets its model answer
  always @(posedge clk_i) begin : rev_check
    return_packet_t exp;
    if (!reset_i) begin
      if (link_rev_v_o && link_rev_ready_i) begin
        if (exp_rev_q.size() == 0) begin
          other_errors++;
          $display("%s: response sent with no request outstanding", test_name);
        end else begin
          exp = exp_rev_q.pop_front();
          answered_cnt++;
          if (link_rev_data_o !== exp) begin
            value_errors++;
            $display("ERROR %s: link_rev_data_o expected %h actual %h",
                     test_name, exp, link_rev_data_o);
          end
        end
      end
      if (link_fwd_v_i && link_fwd_ready_o) begin
        exp_rev_q.push_back(ref_mem_response(link_fwd_data_i));
        accepted_cnt++;
      end
    end
  end

  // incoming returns, head checked before the same-cycle enqueue
  always @(posedge clk_i) begin : ret_check
    return_packet_t exp;
    if (!reset_i) begin
      if (return_packet_yumi_i) begin
        if (!return_packet_v_o || exp_ret_q.size() == 0) begin
          other_errors++;
          $display("%s: dequeue with no return packet waiting", test_name);
        end else begin
          exp = exp_ret_q.pop_front();
          if (return_packet_o !== exp) begin
            value_errors++;
            $display("ERROR %s: return_packet_o expected %h actual %h",
                     test_name, exp, return_packet_o);
          end
        end
      end
      if (link_rev_v_i)
        exp_ret_q.push_back(link_rev_data_i);
    end
  end

  // zero latency client to link paths
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (link_fwd_v_o !== packet_v_i) begin
        value_errors++;
        $display("ERROR %s: link_fwd_v_o expected %b actual %b",
                 test_name, packet_v_i, link_fwd_v_o);
      end
      if (link_fwd_data_o !== packet_i) begin
        value_errors++;
        $display("ERROR %s: link_fwd_data_o expected %h actual %h",
                 test_name, packet_i, link_fwd_data_o);
      end
      if (packet_ready_o !== link_fwd_ready_i) begin
        value_errors++;
        $display("ERROR %s: packet_ready_o expected %b actual %b",
                 test_name, link_fwd_ready_i, packet_ready_o);
      end
    end
  end

  // one request in the responder plus four queued before ready may drop
  always @(negedge clk_i) begin
    if (checks_on) begin
      if (!link_fwd_ready_o && (accepted_cnt - answered_cnt) < 5) begin
        value_errors++;
        $display("ERROR %s: link_fwd_ready_o expected 1 actual 0, %0d outstanding",
                 test_name, accepted_cnt - answered_cnt);
      end
      check_bit("return_packet_fifo_full_o", return_packet_fifo_full_o,
                exp_ret_q.size() == 2);
    end
  end

  // ------------------------------
  // watchdog
  // ------------------------------
  initial begin
    repeat (timeout_cycles_lp) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", timeout_cycles_lp);
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    $display(">>> FAIL");
    $finish;
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    return_packet_t ret_a;
    return_packet_t ret_b;
    int             sent;
    void'($urandom(60239));
    reset_i              = 1'b1;
    link_fwd_v_i         = 1'b0;
    link_fwd_data_i      = '0;
    link_fwd_ready_i     = 1'b1;
    link_rev_v_i         = 1'b0;
    link_rev_data_i      = '0;
    packet_v_i           = 1'b0;
    packet_i             = '0;
    return_packet_yumi_i = 1'b0;
    value_errors         = 0;
    other_errors         = 0;
    accepted_cnt         = 0;
    answered_cnt         = 0;
    rev_mode             = 0;
    checks_on            = 1'b0;
    test_name            = "reset_state";

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    check_bit("link_fwd_ready_o", link_fwd_ready_o, 1'b1);
    check_bit("link_rev_v_o", link_rev_v_o, 1'b0);
    check_bit("return_packet_v_o", return_packet_v_o, 1'b0);
    check_bit("return_packet_fifo_full_o", return_packet_fifo_full_o, 1'b0);
    checks_on = 1'b1;

    // store then load of the same word
    test_name = "store_load";
    written_q.push_back(8'h2a);
    send_request(make_request(op_store_lp, 8'h2a, 32'hdeadbeef, 4'd3, 4'd5));
    send_request(make_request(op_load_lp, 8'h2a, 32'h0, 4'd6, 4'd7));
    wait_drain();

    test_name = "random_mix";
    send_random_requests(40);
    wait_drain();

    test_name = "reverse_backpressure";
    rev_mode  = 1;
    send_random_requests(40);
    rev_mode = 0;
    wait_drain();

    // reverse link blocked, five requests fill responder and request FIFO
    test_name = "reverse_stall";
    rev_mode  = 2;
    @(negedge clk_i);
    repeat (5) send_request(random_request());
    repeat (2) @(negedge clk_i);
    check_bit("link_fwd_ready_o", link_fwd_ready_o, 1'b0);
    rev_mode = 0;
    wait_drain();

    test_name = "passthrough";
    repeat (20) begin
      packet_v_i       = 1'($urandom % 2);
      packet_i         = packet_t'({$urandom, $urandom});
      link_fwd_ready_i = 1'($urandom % 2);
      @(negedge clk_i);
    end
    packet_v_i       = 1'b0;
    link_fwd_ready_i = 1'b1;

    // two returns with no dequeue fill the return FIFO
    test_name       = "incoming_returns";
    ret_a           = return_packet_t'({$urandom, $urandom});
    ret_b           = return_packet_t'({$urandom, $urandom});
    link_rev_v_i    = 1'b1;
    link_rev_data_i = ret_a;
    @(negedge clk_i);
    link_rev_data_i = ret_b;
    @(negedge clk_i);
    link_rev_v_i = 1'b0;
    check_bit("return_packet_fifo_full_o", return_packet_fifo_full_o, 1'b1);
    check_bit("return_packet_v_o", return_packet_v_o, 1'b1);
    drain_returns();

    // random dequeues, a send into a full FIFO only with a dequeue
    test_name = "random_returns";
    sent      = 0;
    while (sent < 30) begin
      return_packet_yumi_i = return_packet_v_o && (($urandom % 2) == 0);
      if (($urandom % 3) != 0 && (!return_packet_fifo_full_o || return_packet_yumi_i)) begin
        link_rev_v_i    = 1'b1;
        link_rev_data_i = return_packet_t'({$urandom, $urandom});
        sent++;
      end else begin
        link_rev_v_i = 1'b0;
      end
      @(negedge clk_i);
    end
    link_rev_v_i = 1'b0;
    drain_returns();

    repeat (4) @(negedge clk_i);
    if (exp_rev_q.size() != 0 || exp_ret_q.size() != 0) begin
      other_errors++;
      $display("traffic left over at the end of the run");
    end
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
source/manycore_pkg.sv
source/fifo_small.sv
source/two_fifo.sv
source/manycore_endpoint.sv
source/local_mem_responder.sv
source/manycore_tile.sv
tests/tb_manycore_tile.sv

// ==== Makefile ====
# build and run the manycore tile testbench with Verilator

sim:
	verilator --binary --timing --assert --top-module tb_manycore_tile -Mdir obj_dir -f verilog.f
	./obj_dir/Vtb_manycore_tile > sim.log 2>&1 || true
	cat sim.log
	@if grep -q '>>> FAIL' sim.log; then exit 1; fi
	@grep -q '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
